//--- run.sh
#!/bin/sh
# build and run the SD card controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_sd_card_ctrl -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
echo "pass message not found"
exit 1

//--- sd_card_ctrl.sv
`timescale 1ns/1ns

module sd_card_ctrl (
  input  logic        CLK,
  input  logic        RST,
  input  logic        req_valid,
  output logic        req_ready,
  input  logic        req_write,
  input  logic [31:0] req_addr,
  input  logic        wr_valid,
  output logic        wr_ready,
  input  logic [7:0]  wr_data,
  output logic        rd_valid,
  input  logic        rd_ready,
  output logic [7:0]  rd_data,
  output logic        done,
  output logic        error,
  output logic        cs,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso
);

  // sequencer to link
  logic             op_valid;
  logic             op_ready;
  sd_pkg::link_op_e op;
  sd_pkg::sd_cmd_e  cmd;
  logic [31:0]      arg;
  logic [7:0]       tx_byte;
  logic             res_valid;
  logic [7:0]       res_byte;
  logic             timeout;

  sd_sequencer u_seq (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .done      (done),
    .error     (error),
    .cs        (cs),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op        (op),
    .cmd       (cmd),
    .arg       (arg),
    .tx_byte   (tx_byte),
    .res_valid (res_valid),
    .res_byte  (res_byte),
    .timeout   (timeout)
  );

  sd_link u_link (
    .CLK       (CLK),
    .RST       (RST),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op        (op),
    .cmd       (cmd),
    .arg       (arg),
    .tx_byte   (tx_byte),
    .res_valid (res_valid),
    .res_byte  (res_byte),
    .timeout   (timeout),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

//--- sd_card_model.sv
`timescale 1ns/1ns

module sd_card_model (
  input  logic        cs,
  input  logic        sclk,
  input  logic        mosi,
  output logic        miso,
  input  logic [31:0] reject_addr
);

  typedef enum int {M_CMD, M_WR_TOKEN, M_WR_DATA, M_WR_CRC} mode_e;

  logic [7:0]  mem [sd_pkg::BLOCK_BYTES];
  logic [7:0]  out_sh      = 8'hFF;
  logic [7:0]  next_out    = 8'hFF;
  logic [7:0]  in_sh       = 8'h00;
  logic [7:0]  frame [6];
  logic [7:0]  resp_q [$];
  int          bits        = 0;
  int          cmd_len     = 0;
  int          wr_idx      = 0;
  int          crc_cnt     = 0;
  int          idle_edges  = 0;
  int          cmd_count   = 0;
  logic [31:0] last_arg    = '0;
  bit          cmd0_seen   = 1'b0;
  bit          idle_ok     = 1'b0;
  bit          acmd41_seen = 1'b0;
  mode_e       mode        = M_CMD;

  assign miso = out_sh[7];

  // ------------------------------------------------------------
  // command decode, answers are queued byte by byte
  // ------------------------------------------------------------
  task automatic run_command();
    logic [5:0]  idx;
    logic [31:0] a;
    int          i;
    idx = frame[0][5:0];
    a = {frame[1], frame[2], frame[3], frame[4]};
    cmd_count++;
    last_arg = a;
    case (sd_pkg::sd_cmd_e'(idx))
      sd_pkg::CMD0: begin
        if (!cmd0_seen) idle_ok = (idle_edges >= 74);
        cmd0_seen = 1'b1;
        resp_q.push_back(8'h01);
      end
      sd_pkg::CMD8: begin
        // R7 echoes the argument
        resp_q.push_back(8'h01);
        resp_q.push_back(a[31:24]);
        resp_q.push_back(a[23:16]);
        resp_q.push_back(a[15:8]);
        resp_q.push_back(a[7:0]);
      end
      sd_pkg::CMD55:  resp_q.push_back(acmd41_seen ? 8'h00 : 8'h01);
      sd_pkg::ACMD41: begin
        resp_q.push_back(acmd41_seen ? 8'h00 : 8'h01);
        acmd41_seen = 1'b1;
      end
      sd_pkg::CMD17: begin
        if (a == reject_addr) begin
          resp_q.push_back(8'h04);
        end else begin
          resp_q.push_back(8'h00);
          resp_q.push_back(8'hFF);
          resp_q.push_back(sd_pkg::DATA_TOKEN);
          for (i = 0; i < sd_pkg::BLOCK_BYTES; i++) resp_q.push_back(mem[i]);
          // crc is not checked by the host
          resp_q.push_back(8'h00);
          resp_q.push_back(8'h00);
        end
      end
      sd_pkg::CMD24: begin
        if (a == reject_addr) begin
          resp_q.push_back(8'h04);
        end else begin
          resp_q.push_back(8'h00);
          mode = M_WR_TOKEN;
        end
      end
      default: resp_q.push_back(8'h04);
    endcase
  endtask

  task automatic take_byte(input logic [7:0] b);
    case (mode)
      M_CMD: begin
        // a frame opens with start bits 01
        if (cmd_len > 0 || b[7:6] == 2'b01) begin
          frame[cmd_len] = b;
          cmd_len++;
          if (cmd_len == 6) begin
            cmd_len = 0;
            run_command();
          end
        end
      end
      M_WR_TOKEN: begin
        if (b == sd_pkg::DATA_TOKEN) begin
          mode = M_WR_DATA;
          wr_idx = 0;
        end
      end
      M_WR_DATA: begin
        mem[wr_idx] = b;
        wr_idx++;
        if (wr_idx == sd_pkg::BLOCK_BYTES) begin
          mode = M_WR_CRC;
          crc_cnt = 0;
        end
      end
      default: begin
        crc_cnt++;
        if (crc_cnt == 2) begin
          // data accepted, then two busy bytes
          resp_q.push_back(8'h05);
          resp_q.push_back(8'h00);
          resp_q.push_back(8'h00);
          mode = M_CMD;
        end
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // SPI mode 0 bit level
  // ------------------------------------------------------------
  initial begin
    for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
      // i xor 5A, high address bits folded in
      mem[i] = 8'h5A ^ 8'(i) ^ 8'(i >> 8);
    end
    forever begin
      @(sclk);
      if (sclk) begin
        in_sh = {in_sh[6:0], mosi};
        if (cs && !cmd0_seen) idle_edges++;
        bits++;
        if (bits == 8) begin
          bits = 0;
          if (!cs) take_byte(in_sh);
          next_out = (resp_q.size() > 0) ? resp_q.pop_front() : 8'hFF;
        end
      end else begin
        // new byte goes out on the falling edge that ends the last one
        out_sh = (bits == 0) ? next_out : {out_sh[6:0], 1'b1};
      end
    end
  end

endmodule

//--- sd_link.sv
`timescale 1ns/1ns

module sd_link (
  input  logic             CLK,
  input  logic             RST,
  input  logic             op_valid,
  output logic             op_ready,
  input  sd_pkg::link_op_e op,
  input  sd_pkg::sd_cmd_e  cmd,
  input  logic [31:0]      arg,
  input  logic [7:0]       tx_byte,
  output logic             res_valid,
  output logic [7:0]       res_byte,
  output logic             timeout,
  output logic             sclk,
  output logic             mosi,
  input  logic             miso
);

  logic        tx_valid;
  logic        tx_ready;
  logic [7:0]  tx_data;
  logic        rx_valid;
  logic [7:0]  rx_data;

  logic        active;
  logic        in_flight;
  logic        rx_done;
  logic        is_cmd;
  logic        polling;
  logic [2:0]  byte_idx;
  logic [3:0]  poll_cnt;
  logic [47:0] frame;
  logic [7:0]  crc;

  // byte index 6 means the frame is out and we wait for R1
  assign polling  = (byte_idx == 3'd6);
  assign op_ready = !active;
  assign tx_valid = active && !in_flight;
  assign tx_data  = polling ? sd_pkg::IDLE_BYTE : frame[47:40];

  // only CMD0 and CMD8 are checked by the card in SPI mode
  always_comb begin
    case (cmd)
      sd_pkg::CMD0: crc = sd_pkg::CRC_CMD0;
      sd_pkg::CMD8: crc = sd_pkg::CRC_CMD8;
      default:      crc = 8'hFF;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active    <= 1'b0;
      in_flight <= 1'b0;
      rx_done   <= 1'b0;
      is_cmd    <= 1'b0;
      byte_idx  <= '0;
      poll_cnt  <= '0;
      res_valid <= 1'b0;
      timeout   <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      if (op_valid && !active) begin
        active   <= 1'b1;
        is_cmd   <= (op == sd_pkg::LINK_CMD);
        // a raw byte is sent as the last byte of a one-byte frame
        byte_idx <= (op == sd_pkg::LINK_CMD) ? 3'd0 : 3'd5;
        poll_cnt <= '0;
      end else if (tx_valid && tx_ready) begin
        in_flight <= 1'b1;
      end else if (rx_valid) begin
        if (!is_cmd || (polling && !rx_data[7])) begin
          rx_done <= 1'b1;
          timeout <= 1'b0;
        end else if (polling && poll_cnt == 4'(sd_pkg::R1_POLL_LIMIT - 1)) begin
          rx_done <= 1'b1;
          timeout <= 1'b1;
        end else begin
          in_flight <= 1'b0;
          if (polling) begin
            poll_cnt <= poll_cnt + 4'd1;
          end else begin
            byte_idx <= byte_idx + 3'd1;
          end
        end
      end else if (rx_done && tx_ready) begin
        // hold the result until sclk is back low
        rx_done   <= 1'b0;
        in_flight <= 1'b0;
        active    <= 1'b0;
        res_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (op_valid && !active) begin
      if (op == sd_pkg::LINK_CMD) begin
        frame <= {2'b01, cmd, arg, crc};
      end else begin
        frame <= {tx_byte, 40'd0};
      end
    end else if (rx_valid && !polling) begin
      frame <= {frame[39:0], 8'hFF};
    end
    if (rx_valid) begin
      res_byte <= rx_data;
    end
  end

  spi_byte_engine u_engine (
    .CLK      (CLK),
    .RST      (RST),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso)
  );

endmodule

//--- sd_pkg.sv
package sd_pkg;

  // ------------------------------------------------------------
  // timing and sizes
  // ------------------------------------------------------------
  // CLK cycles per SCLK half period
  localparam int CLK_DIV          = 5;
  localparam int BLOCK_BYTES      = 512;
  // 10 bytes give 80 idle clocks, card needs at least 74
  localparam int INIT_BYTES       = 10;
  localparam int R1_POLL_LIMIT    = 8;
  localparam int CMD0_RETRIES     = 16;
  localparam int ACMD41_RETRIES   = 255;
  localparam int TOKEN_POLL_LIMIT = 1024;
  localparam int BUSY_POLL_LIMIT  = 4096;

  // ------------------------------------------------------------
  // bytes and arguments on the wire
  // ------------------------------------------------------------
  localparam logic [7:0]  DATA_TOKEN = 8'hFE;
  localparam logic [7:0]  IDLE_BYTE  = 8'hFF;
  localparam logic [7:0]  CRC_CMD0   = 8'h95;
  localparam logic [7:0]  CRC_CMD8   = 8'h87;
  // 2.7-3.6 V range plus check pattern AA
  localparam logic [31:0] CMD8_ARG   = 32'h0000_01AA;
  // HCS bit set
  localparam logic [31:0] ACMD41_ARG = 32'h4000_0000;

  typedef enum logic [5:0] {
    CMD0   = 6'd0,
    CMD8   = 6'd8,
    CMD17  = 6'd17,
    CMD24  = 6'd24,
    ACMD41 = 6'd41,
    CMD55  = 6'd55
  } sd_cmd_e;

  typedef enum logic {
    LINK_CMD,
    LINK_BYTE
  } link_op_e;

  typedef enum logic [4:0] {
    S_START, S_INIT_IDLE, S_CMD0, S_CMD8, S_CMD8_TAIL, S_CMD55, S_ACMD41,
    S_READY, S_RD_CMD, S_RD_TOKEN, S_RD_DATA, S_RD_OUT, S_RD_CRC,
    S_WR_CMD, S_WR_TOKEN, S_WR_DATA, S_WR_SEND, S_WR_CRC, S_WR_RESP,
    S_WR_BUSY, S_FINISH
  } seq_state_e;

endpackage

//--- sd_sequencer.sv
`timescale 1ns/1ns

module sd_sequencer (
  input  logic             CLK,
  input  logic             RST,
  input  logic             req_valid,
  output logic             req_ready,
  input  logic             req_write,
  input  logic [31:0]      req_addr,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  logic [7:0]       wr_data,
  output logic             rd_valid,
  input  logic             rd_ready,
  output logic [7:0]       rd_data,
  output logic             done,
  output logic             error,
  output logic             cs,
  output logic             op_valid,
  input  logic             op_ready,
  output sd_pkg::link_op_e op,
  output sd_pkg::sd_cmd_e  cmd,
  output logic [31:0]      arg,
  output logic [7:0]       tx_byte,
  input  logic             res_valid,
  input  logic [7:0]       res_byte,
  input  logic             timeout
);

  sd_pkg::seq_state_e state;
  logic [12:0]        cnt;
  logic               issued;
  logic               needs_op;
  logic [31:0]        addr_q;
  logic [7:0]         data_q;

  assign req_ready = (state == sd_pkg::S_READY);
  assign wr_ready  = (state == sd_pkg::S_WR_DATA);
  assign rd_valid  = (state == sd_pkg::S_RD_OUT);
  // states that wait on the host instead of the link
  assign needs_op  = !(state inside {sd_pkg::S_START, sd_pkg::S_READY, sd_pkg::S_RD_OUT,
                                     sd_pkg::S_WR_DATA, sd_pkg::S_FINISH});
  assign op_valid  = needs_op && !issued;

  // ------------------------------------------------------------
  // link operation per state
  // ------------------------------------------------------------
  always_comb begin
    op      = sd_pkg::LINK_BYTE;
    cmd     = sd_pkg::CMD0;
    arg     = '0;
    tx_byte = sd_pkg::IDLE_BYTE;
    case (state)
      sd_pkg::S_CMD0: op = sd_pkg::LINK_CMD;
      sd_pkg::S_CMD8: begin
        op  = sd_pkg::LINK_CMD;
        cmd = sd_pkg::CMD8;
        arg = sd_pkg::CMD8_ARG;
      end
      sd_pkg::S_CMD55: begin
        op  = sd_pkg::LINK_CMD;
        cmd = sd_pkg::CMD55;
      end
      sd_pkg::S_ACMD41: begin
        op  = sd_pkg::LINK_CMD;
        cmd = sd_pkg::ACMD41;
        arg = sd_pkg::ACMD41_ARG;
      end
      sd_pkg::S_RD_CMD: begin
        op  = sd_pkg::LINK_CMD;
        cmd = sd_pkg::CMD17;
        arg = addr_q;
      end
      sd_pkg::S_WR_CMD: begin
        op  = sd_pkg::LINK_CMD;
        cmd = sd_pkg::CMD24;
        arg = addr_q;
      end
      sd_pkg::S_WR_TOKEN: tx_byte = sd_pkg::DATA_TOKEN;
      sd_pkg::S_WR_SEND:  tx_byte = data_q;
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // main FSM, op states advance on res_valid
  // ------------------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= sd_pkg::S_START;
      cnt    <= '0;
      issued <= 1'b0;
      cs     <= 1'b1;
      done   <= 1'b0;
      error  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (op_valid && op_ready) issued <= 1'b1;
      if (res_valid) issued <= 1'b0;
      case (state)
        sd_pkg::S_START: begin
          cs    <= 1'b1;
          cnt   <= '0;
          state <= sd_pkg::S_INIT_IDLE;
        end
        sd_pkg::S_INIT_IDLE: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (cnt == 13'(sd_pkg::INIT_BYTES - 1)) begin
            cnt   <= '0;
            cs    <= 1'b0;
            state <= sd_pkg::S_CMD0;
          end
        end
        sd_pkg::S_CMD0: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (!timeout && res_byte == 8'h01) begin
            state <= sd_pkg::S_CMD8;
          end else if (cnt == 13'(sd_pkg::CMD0_RETRIES - 1)) begin
            state <= sd_pkg::S_START;
          end
        end
        sd_pkg::S_CMD8: if (res_valid) begin
          cnt   <= '0;
          state <= timeout ? sd_pkg::S_START : sd_pkg::S_CMD8_TAIL;
        end
        sd_pkg::S_CMD8_TAIL: if (res_valid) begin
          // R7 carries 4 bytes after R1
          cnt <= cnt + 13'd1;
          if (cnt == 13'd3) begin
            cnt   <= '0;
            state <= sd_pkg::S_CMD55;
          end
        end
        sd_pkg::S_CMD55: if (res_valid) state <= sd_pkg::S_ACMD41;
        sd_pkg::S_ACMD41: if (res_valid) begin
          cnt   <= cnt + 13'd1;
          state <= sd_pkg::S_CMD55;
          if (!timeout && res_byte == 8'h00) begin
            cs    <= 1'b1;
            state <= sd_pkg::S_READY;
          end else if (cnt == 13'(sd_pkg::ACMD41_RETRIES - 1)) begin
            state <= sd_pkg::S_START;
          end
        end
        sd_pkg::S_READY: if (req_valid) begin
          cnt   <= '0;
          cs    <= 1'b0;
          state <= req_write ? sd_pkg::S_WR_CMD : sd_pkg::S_RD_CMD;
        end
        sd_pkg::S_RD_CMD, sd_pkg::S_WR_CMD: if (res_valid) begin
          if (timeout || res_byte != 8'h00) begin
            cs    <= 1'b1;
            error <= 1'b1;
            state <= sd_pkg::S_FINISH;
          end else begin
            state <= (state == sd_pkg::S_RD_CMD) ? sd_pkg::S_RD_TOKEN : sd_pkg::S_WR_TOKEN;
          end
        end
        sd_pkg::S_RD_TOKEN: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (res_byte == sd_pkg::DATA_TOKEN) begin
            cnt   <= '0;
            state <= sd_pkg::S_RD_DATA;
          end else if (cnt == 13'(sd_pkg::TOKEN_POLL_LIMIT - 1)) begin
            cs    <= 1'b1;
            error <= 1'b1;
            state <= sd_pkg::S_FINISH;
          end
        end
        sd_pkg::S_RD_DATA: if (res_valid) state <= sd_pkg::S_RD_OUT;
        sd_pkg::S_RD_OUT: if (rd_ready) begin
          cnt   <= cnt + 13'd1;
          state <= sd_pkg::S_RD_DATA;
          if (cnt == 13'(sd_pkg::BLOCK_BYTES - 1)) begin
            cnt   <= '0;
            state <= sd_pkg::S_RD_CRC;
          end
        end
        sd_pkg::S_RD_CRC: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (cnt == 13'd1) begin
            cs    <= 1'b1;
            error <= 1'b0;
            state <= sd_pkg::S_FINISH;
          end
        end
        sd_pkg::S_WR_TOKEN: if (res_valid) state <= sd_pkg::S_WR_DATA;
        sd_pkg::S_WR_DATA: if (wr_valid) state <= sd_pkg::S_WR_SEND;
        sd_pkg::S_WR_SEND: if (res_valid) begin
          cnt   <= cnt + 13'd1;
          state <= sd_pkg::S_WR_DATA;
          if (cnt == 13'(sd_pkg::BLOCK_BYTES - 1)) begin
            cnt   <= '0;
            state <= sd_pkg::S_WR_CRC;
          end
        end
        sd_pkg::S_WR_CRC: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (cnt == 13'd1) begin
            cnt   <= '0;
            state <= sd_pkg::S_WR_RESP;
          end
        end
        sd_pkg::S_WR_RESP: if (res_valid) begin
          // xxx0_0101 means data accepted
          if (res_byte[4:0] == 5'h05) begin
            state <= sd_pkg::S_WR_BUSY;
          end else begin
            cs    <= 1'b1;
            error <= 1'b1;
            state <= sd_pkg::S_FINISH;
          end
        end
        sd_pkg::S_WR_BUSY: if (res_valid) begin
          cnt <= cnt + 13'd1;
          if (res_byte == sd_pkg::IDLE_BYTE) begin
            cs    <= 1'b1;
            error <= 1'b0;
            state <= sd_pkg::S_FINISH;
          end else if (cnt == 13'(sd_pkg::BUSY_POLL_LIMIT - 1)) begin
            cs    <= 1'b1;
            error <= 1'b1;
            state <= sd_pkg::S_FINISH;
          end
        end
        sd_pkg::S_FINISH: begin
          done  <= 1'b1;
          state <= sd_pkg::S_READY;
        end
        default: state <= sd_pkg::S_START;
      endcase
    end
  end

  // address, write byte and read byte holding registers
  always_ff @(posedge CLK) begin
    if (req_valid && req_ready) addr_q <= req_addr;
    if (wr_valid && wr_ready) data_q <= wr_data;
    if (state == sd_pkg::S_RD_DATA && res_valid) rd_data <= res_byte;
  end

endmodule

//--- sources.f
sd_pkg.sv
spi_byte_engine.sv
sd_link.sv
sd_sequencer.sv
sd_card_ctrl.sv
tb_clock.sv
sd_card_model.sv
tb_sd_card_ctrl.sv

//--- spi_byte_engine.sv
`timescale 1ns/1ns

module spi_byte_engine (
  input  logic       CLK,
  input  logic       RST,
  input  logic       tx_valid,
  output logic       tx_ready,
  input  logic [7:0] tx_data,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  logic       busy;
  logic       tick;
  logic [7:0] tick_cnt;
  logic [3:0] edge_cnt;
  logic [7:0] tx_sh;

  assign tick     = busy && (tick_cnt == 8'd0);
  assign tx_ready = !busy;
  // first bit is on the line before the first rising edge (mode 0)
  assign mosi     = tx_sh[7];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      tick_cnt <= '0;
      edge_cnt <= '0;
      sclk     <= 1'b0;
      tx_sh    <= 8'hFF;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (tx_valid && !busy) begin
        busy     <= 1'b1;
        tick_cnt <= 8'(sd_pkg::CLK_DIV - 1);
        edge_cnt <= '0;
        tx_sh    <= tx_data;
      end else if (tick) begin
        tick_cnt <= 8'(sd_pkg::CLK_DIV - 1);
        edge_cnt <= edge_cnt + 4'd1;
        sclk     <= !sclk;
        if (sclk) begin
          // falling edge, next bit out, ones fill so mosi ends high
          tx_sh <= {tx_sh[6:0], 1'b1};
          if (edge_cnt == 4'd15) begin
            busy <= 1'b0;
          end
        end else if (edge_cnt == 4'd14) begin
          rx_valid <= 1'b1;
        end
      end else if (busy) begin
        tick_cnt <= tick_cnt - 8'd1;
      end
    end
  end

  // receive shifter, sampled on rising sclk
  always_ff @(posedge CLK) begin
    if (tick && !sclk) begin
      rx_data <= {rx_data[6:0], miso};
    end
  end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic CLK,
  output logic RST
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // two rising edges under reset, released on a falling edge
  initial begin
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

//--- tb_sd_card_ctrl.sv
`timescale 1ns/1ns

module tb_sd_card_ctrl;

  localparam int BLOCK        = sd_pkg::BLOCK_BYTES;
  // one byte exchange plus handshake slack
  localparam int BYTE_CYCLES  = 16 * sd_pkg::CLK_DIV + 2;
  localparam int INIT_TIMEOUT = 200 * BYTE_CYCLES;
  // block, command overhead and back-pressure
  localparam int REQ_TIMEOUT  = 4 * BLOCK * BYTE_CYCLES;
  localparam logic [31:0] REJECT_ADDR = 32'h0000_0BAD;

  logic        CLK;
  logic        RST;
  logic        req_valid;
  logic        req_ready;
  logic        req_write;
  logic [31:0] req_addr;
  logic        wr_valid;
  logic        wr_ready;
  logic [7:0]  wr_data;
  logic        rd_valid;
  logic        rd_ready;
  logic [7:0]  rd_data;
  logic        done;
  logic        error;
  logic        cs;
  logic        sclk;
  logic        mosi;
  logic        miso;

  logic [7:0]  wr_block [BLOCK];
  logic [7:0]  rd_block [BLOCK];
  int          rd_count;
  int          wr_count;
  bit          finished;
  bit          req_err;
  bit          saw_rd_valid;
  int          checks_failed  = 0;
  int          fails_at_start = 0;
  int          tests_run      = 0;
  int          tests_failed   = 0;

  tb_clock clk_gen (
    .CLK (CLK),
    .RST (RST)
  );

  sd_card_ctrl uut (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .done      (done),
    .error     (error),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso)
  );

  sd_card_model model (
    .cs          (cs),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .reject_addr (REJECT_ADDR)
  );

  // ------------------------------------------------------------
  // checking and reporting
  // ------------------------------------------------------------
  // card contents after power-up
  function automatic logic [7:0] fill_byte(input int i);
    logic [15:0] a;
    a = 16'(i);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      checks_failed++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      checks_failed++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (checks_failed == fails_at_start) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
    fails_at_start = checks_failed;
  endtask

  task automatic compare_read(input string name, input bit from_fill);
    int i;
    check_value({name, " error"}, 32'd0, 32'(req_err));
    check_value({name, " count"}, 32'(BLOCK), 32'(rd_count));
    for (i = 0; i < BLOCK; i++) begin
      check_value($sformatf("%s byte %0d", name, i),
                  32'(from_fill ? fill_byte(i) : wr_block[i]), 32'(rd_block[i]));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus where all waits start and end on a falling edge
  // ------------------------------------------------------------
  task automatic wait_req_ready(input int limit, output bit ok);
    int waited;
    waited = 0;
    while (!req_ready && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    ok = req_ready;
  endtask

  task automatic start_request(input logic write, input logic [31:0] addr, output bit ok);
    wait_req_ready(REQ_TIMEOUT, ok);
    if (ok) begin
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      @(negedge CLK);
      req_valid = 1'b0;
    end
  endtask

  task automatic run_read(input string name, input logic [31:0] addr, input bit stall);
    int waited;
    bit ok;
    waited = 0;
    rd_count = 0;
    saw_rd_valid = 1'b0;
    finished = 1'b0;
    req_err = 1'b0;
    start_request(1'b0, addr, ok);
    check_true(ok, {name, ": req_ready never rose"});
    while (ok && !finished && waited < REQ_TIMEOUT) begin
      if (done) begin
        finished = 1'b1;
        req_err = error;
        check_true(cs, {name, ": cs still low at done"});
      end else begin
        // rd_valid is stable here, so a transfer on the next edge is known now
        rd_ready = stall ? 1'($urandom % 2) : 1'b1;
        if (rd_valid) saw_rd_valid = 1'b1;
        if (rd_valid && rd_ready) begin
          if (rd_count < BLOCK) rd_block[rd_count] = rd_data;
          rd_count++;
        end
        @(negedge CLK);
        waited++;
      end
    end
    rd_ready = 1'b0;
    if (ok) check_true(finished, {name, ": timed out waiting for done"});
  endtask

  task automatic run_write(input string name, input logic [31:0] addr);
    int waited;
    bit ok;
    bit taken;
    waited = 0;
    wr_count = 0;
    taken = 1'b0;
    finished = 1'b0;
    req_err = 1'b0;
    start_request(1'b1, addr, ok);
    check_true(ok, {name, ": req_ready never rose"});
    while (ok && !finished && waited < REQ_TIMEOUT) begin
      if (done) begin
        finished = 1'b1;
        req_err = error;
        check_true(cs, {name, ": cs still low at done"});
      end else begin
        if (taken) wr_valid = 1'b0;
        // once raised, wr_valid holds until the byte is taken
        if (!wr_valid && wr_count < BLOCK) wr_valid = 1'($urandom % 2);
        if (wr_count < BLOCK) wr_data = wr_block[wr_count];
        taken = wr_valid && wr_ready;
        if (taken) wr_count++;
        @(negedge CLK);
        waited++;
      end
    end
    wr_valid = 1'b0;
    if (ok) check_true(finished, {name, ": timed out waiting for done"});
  endtask

  initial begin
    bit ok;
    int i;
    void'($urandom(95780));
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    wr_valid  = 1'b0;
    wr_data   = '0;
    rd_ready  = 1'b0;
    for (i = 0; i < BLOCK; i++) wr_block[i] = 8'($urandom);

    // reset values, then power-up sequence
    @(negedge CLK);
    check_value("reset outputs", 32'h0000_00A0,
                32'({cs, sclk, mosi, req_ready, wr_ready, rd_valid, done, error}));
    wait_req_ready(INIT_TIMEOUT, ok);
    check_true(ok, "init: req_ready did not rise after reset");
    check_value("init idle clocks", 32'd1, 32'(model.idle_ok));
    // CMD0, CMD8 and two CMD55/ACMD41 pairs since the card leaves idle on the second
    check_value("init command count", 32'd6, 32'(model.cmd_count));
    end_test("init");

    run_read("read_7", 32'd7, 1'b0);
    compare_read("read_7", 1'b1);
    check_value("read_7 last arg", 32'd7, model.last_arg);
    end_test("read_7");

    run_write("write_9", 32'd9);
    check_value("write_9 error", 32'd0, 32'(req_err));
    check_value("write_9 bytes taken", 32'(BLOCK), 32'(wr_count));
    for (i = 0; i < BLOCK; i++) begin
      check_value($sformatf("write_9 card byte %0d", i), 32'(wr_block[i]),
                  32'(model.mem[i]));
    end
    end_test("write_9");

    run_read("readback_9", 32'd9, 1'b1);
    compare_read("readback_9", 1'b0);
    end_test("readback_9");

    // the card holds one block, so it still carries the written data
    run_read("reject", REJECT_ADDR, 1'b0);
    check_value("reject error", 32'd1, 32'(req_err));
    check_value("reject count", 32'd0, 32'(rd_count));
    check_true(!saw_rd_valid, "reject: rd_valid appeared on a rejected read");
    run_read("read_after_reject", 32'd7, 1'b0);
    compare_read("read_after_reject", 1'b0);
    end_test("reject");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, checks_failed);
    if (checks_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
